/* all.f */
+incdir+src
src/lsq_pkg.sv
src/lsq_fifo.sv
src/lsq_store_queue.sv
src/lsq_intake.sv
src/lsq_issue.sv
src/load_store_queue.sv
tests/tb_load_store_queue.sv

/* tests/tb_load_store_queue.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module tb_load_store_queue;

    import lsq_pkg::*;

    localparam int OFF_W = `LSQ_OFFSET_W;
    localparam int PAGE_W = `LSQ_PAGE_W;
    localparam int ADDR_W = `LSQ_PAGE_W + `LSQ_OFFSET_W;
    localparam int TIMEOUT = 200;

    // Wait conditions
    localparam int W_LOAD_ROOM = 0;
    localparam int W_STORE_ROOM = 1;
    localparam int W_LOADS_DRAINED = 2;
    localparam int W_STORES_DRAINED = 3;
    localparam int W_STORE_ACKED = 4;
    localparam int W_IDLE = 5;

    // Expected requests kept oldest first
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [`LSQ_ID_W-1:0] id;
    } load_ref_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [`LSQ_DATA_W-1:0] data;
        logic [`LSQ_BE_W-1:0] be;
    } store_ref_t;

    logic clk;
    logic rst = 1'b1;
    logic op_push = 1'b0;
    ls_op_t op_kind = LS_LOAD;
    logic [`LSQ_OFFSET_W-1:0] op_offset = '0;
    logic [`LSQ_ID_W-1:0] op_id = '0;
    logic [`LSQ_DATA_W-1:0] op_data = '0;
    logic [`LSQ_BE_W-1:0] op_be = '0;
    logic addr_push = 1'b0;
    logic addr_rnw = 1'b0;
    logic [`LSQ_PAGE_W-1:0] addr_page = '0;
    logic addr_discard = 1'b0;
    logic store_retire = 1'b0;
    logic load_ack = 1'b0;
    logic store_ack = 1'b0;
    logic load_valid;
    logic [ADDR_W-1:0] load_addr;
    logic [`LSQ_ID_W-1:0] load_id;
    logic store_valid;
    logic [ADDR_W-1:0] store_addr;
    logic [`LSQ_DATA_W-1:0] store_data;
    logic [`LSQ_BE_W-1:0] store_be;
    logic full;
    logic empty;
    logic sq_empty;

    load_ref_t load_exp[$];
    store_ref_t store_exp[$];
    integer seed = 32'h8764_43e9;
    int errors = 0;
    int errors_mark = 0;
    int tests_done = 0;
    // Retires of stores that must reach memory and their acks
    int retire_count = 0;
    int store_ack_count = 0;
    int ack_mark = 0;
    logic store_ack_en = 1'b1;

    load_store_queue dut_i (
        .clk(clk),
        .rst(rst),
        .op_push(op_push),
        .op_kind(op_kind),
        .op_offset(op_offset),
        .op_id(op_id),
        .op_data(op_data),
        .op_be(op_be),
        .addr_push(addr_push),
        .addr_rnw(addr_rnw),
        .addr_page(addr_page),
        .addr_discard(addr_discard),
        .store_retire(store_retire),
        .load_ack(load_ack),
        .store_ack(store_ack),
        .load_valid(load_valid),
        .load_addr(load_addr),
        .load_id(load_id),
        .store_valid(store_valid),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_be(store_be),
        .full(full),
        .empty(empty),
        .sq_empty(sq_empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // Memory model
    //////////////////////////////

    // One-cycle ack after a random delay and only while valid is high
    always @(posedge clk) begin
        if (rst || load_ack)
            load_ack <= 1'b0;
        else if (load_valid && (($random(seed) & 3) != 0))
            load_ack <= 1'b1;
    end

    always @(posedge clk) begin
        if (rst || store_ack)
            store_ack <= 1'b0;
        else if (store_ack_en && store_valid && (($random(seed) & 3) != 0))
            store_ack <= 1'b1;
    end

    // Compare every accepted request against the oldest expected one
    always @(posedge clk) begin
        load_ref_t lr;
        store_ref_t sr;
        if (!rst) begin
            if (load_valid && load_exp.size() == 0) begin
                $display("load_valid raised at %0t ns with no load outstanding", $time);
                errors++;
            end else if (load_valid && load_ack) begin
                lr = load_exp.pop_front();
                check_value("load_addr", load_addr, lr.addr);
                check_value("load_id", load_id, lr.id);
            end
            if (store_valid && store_exp.size() == 0) begin
                $display("store_valid raised at %0t ns with no store outstanding", $time);
                errors++;
            end else if (store_valid && store_ack) begin
                sr = store_exp.pop_front();
                check_value("store_addr", store_addr, sr.addr);
                check_value("store_data", store_data, sr.data);
                check_value("store_be", store_be, sr.be);
                store_ack_count <= store_ack_count + 1;
            end
        end
    end

    //////////////////////////////
    // Protocol properties
    //////////////////////////////

    // Request held steady under back-pressure
    load_hold: assert property (@(posedge clk) disable iff (rst)
        load_valid && !load_ack |=> load_valid && $stable(load_addr) && $stable(load_id))
    else begin
        $display("Load request dropped or changed before load_ack at %0t ns", $time);
        errors++;
    end

    store_hold: assert property (@(posedge clk) disable iff (rst)
        store_valid && !store_ack |=> store_valid && $stable(store_addr)
            && $stable(store_data) && $stable(store_be))
    else begin
        $display("Store request dropped or changed before store_ack at %0t ns", $time);
        errors++;
    end

    // No store goes out ahead of its retire
    store_retired: assert property (@(posedge clk) disable iff (rst)
        store_valid |-> retire_count > store_ack_count)
    else begin
        $display("store_valid raised at %0t ns before the store was retired", $time);
        errors++;
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Drivers start right after a rising edge and end one edge later
    task automatic issue_op(input ls_op_t kind, input logic [OFF_W-1:0] offset,
                            input logic [`LSQ_ID_W-1:0] id, input logic [31:0] data,
                            input logic [`LSQ_BE_W-1:0] be);
        op_push <= 1'b1;
        op_kind <= kind;
        op_offset <= offset;
        op_id <= id;
        op_data <= data;
        op_be <= be;
        @(posedge clk);
        op_push <= 1'b0;
    endtask

    task automatic send_addr(input logic rnw, input logic [PAGE_W-1:0] page,
                             input logic discard);
        addr_push <= 1'b1;
        addr_rnw <= rnw;
        addr_page <= page;
        addr_discard <= discard;
        @(posedge clk);
        addr_push <= 1'b0;
    endtask

    // counted is low for a faulted store that never reaches memory
    task automatic retire_store(input bit counted);
        store_retire <= 1'b1;
        if (counted)
            retire_count <= retire_count + 1;
        @(posedge clk);
        store_retire <= 1'b0;
    endtask

    task automatic idle_cycles(input int n, input bit load_must_idle);
        for (int k = 0; k < n; k++) begin
            if (load_must_idle)
                check_value("load_valid", load_valid, 1'b0);
            @(posedge clk);
        end
    endtask

    function automatic bit condition_met(input int which);
        case (which)
            W_LOAD_ROOM: return load_exp.size() < `LSQ_LQ_DEPTH;
            W_STORE_ROOM: return !full;
            W_LOADS_DRAINED: return load_exp.size() == 0;
            W_STORES_DRAINED: return store_exp.size() == 0;
            W_STORE_ACKED: return store_ack_count > ack_mark;
            default: return empty && sq_empty && !load_valid && !store_valid;
        endcase
    endfunction

    // Bounded wait that can also insist no load is offered meanwhile
    task automatic wait_until(input int which, input string what, input bit load_must_idle);
        int cycles;
        cycles = 0;
        while (!condition_met(which)) begin
            if (load_must_idle)
                check_value("load_valid", load_valid, 1'b0);
            if (cycles == TIMEOUT) begin
                $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
                $display("=== FAIL ===");
                $finish;
            end
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %-22s done, %0d errors", name, errors - errors_mark);
        errors_mark = errors;
        tests_done++;
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin
        logic [OFF_W-1:0] offset;
        logic [PAGE_W-1:0] page;
        logic [31:0] data;
        logic [`LSQ_BE_W-1:0] be;
        int gap;

        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("load_valid", load_valid, 1'b0);
        check_value("store_valid", store_valid, 1'b0);
        check_value("full", full, 1'b0);
        check_value("empty", empty, 1'b1);
        check_value("sq_empty", sq_empty, 1'b1);
        end_test("reset state");

        // Address either queued early or bypassed as the load becomes head
        for (int i = 0; i < 16; i++) begin
            wait_until(W_LOAD_ROOM, "load queue room", 1'b0);
            offset = OFF_W'($random(seed));
            page = PAGE_W'($random(seed));
            load_exp.push_back({page, offset, 3'(i)});
            issue_op(LS_LOAD, offset, 3'(i), 32'h0, '0);
            gap = $random(seed) & 3;
            idle_cycles(gap, 1'b0);
            send_addr(1'b1, page, 1'b0);
        end
        wait_until(W_LOADS_DRAINED, "random loads to drain", 1'b0);
        end_test("loads in order");

        // Retire comes late so the store sits complete but unretired
        for (int i = 0; i < 6; i++) begin
            wait_until(W_STORE_ROOM, "store queue room", 1'b0);
            offset = OFF_W'($random(seed));
            page = PAGE_W'($random(seed));
            data = $random(seed);
            be = 4'($random(seed));
            store_exp.push_back({page, offset, data, be});
            issue_op(LS_STORE, offset, '0, data, be);
            send_addr(1'b0, page, 1'b0);
            gap = 1 + ($random(seed) & 3);
            idle_cycles(gap, 1'b0);
            retire_store(1'b1);
        end
        wait_until(W_STORES_DRAINED, "stores to drain", 1'b0);
        end_test("stores after retire");

        // Load in the same word as a pending store waits for its ack
        store_ack_en <= 1'b0;
        page = PAGE_W'($random(seed));
        data = $random(seed);
        store_exp.push_back({page, 12'h100, data, 4'hf});
        issue_op(LS_STORE, 12'h100, '0, data, 4'hf);
        send_addr(1'b0, page, 1'b0);
        page = PAGE_W'($random(seed));
        load_exp.push_back({page, 12'h102, 3'd5});
        issue_op(LS_LOAD, 12'h102, 3'd5, 32'h0, '0);
        send_addr(1'b1, page, 1'b0);
        idle_cycles(6, 1'b1);
        retire_store(1'b1);
        idle_cycles(4, 1'b1);
        ack_mark = store_ack_count;
        store_ack_en <= 1'b1;
        wait_until(W_STORE_ACKED, "colliding store ack", 1'b1);
        wait_until(W_LOADS_DRAINED, "unblocked load", 1'b0);

        // Load with a different hash overtakes the unretired store
        store_ack_en <= 1'b0;
        page = PAGE_W'($random(seed));
        data = $random(seed);
        store_exp.push_back({page, 12'h000, data, 4'h3});
        issue_op(LS_STORE, 12'h000, '0, data, 4'h3);
        send_addr(1'b0, page, 1'b0);
        page = PAGE_W'($random(seed));
        load_exp.push_back({page, 12'h004, 3'd6});
        issue_op(LS_LOAD, 12'h004, 3'd6, 32'h0, '0);
        send_addr(1'b1, page, 1'b0);
        wait_until(W_LOADS_DRAINED, "load passing the store", 1'b0);
        check_value("sq_empty", sq_empty, 1'b0);
        retire_store(1'b1);
        store_ack_en <= 1'b1;
        wait_until(W_STORES_DRAINED, "overtaken store", 1'b0);
        end_test("collision blocking");

        // Faulted ops leave silently and the following ones still go out
        issue_op(LS_LOAD, 12'h040, 3'd1, 32'h0, '0);
        send_addr(1'b1, PAGE_W'($random(seed)), 1'b1);
        page = PAGE_W'($random(seed));
        load_exp.push_back({page, 12'h080, 3'd2});
        issue_op(LS_LOAD, 12'h080, 3'd2, 32'h0, '0);
        send_addr(1'b1, page, 1'b0);
        wait_until(W_LOADS_DRAINED, "load after a discard", 1'b0);
        issue_op(LS_STORE, 12'h0c0, '0, $random(seed), 4'hf);
        send_addr(1'b0, PAGE_W'($random(seed)), 1'b1);
        retire_store(1'b0);
        page = PAGE_W'($random(seed));
        data = $random(seed);
        store_exp.push_back({page, 12'h0c4, data, 4'hc});
        issue_op(LS_STORE, 12'h0c4, '0, data, 4'hc);
        send_addr(1'b0, page, 1'b0);
        retire_store(1'b1);
        wait_until(W_STORES_DRAINED, "store after a discard", 1'b0);
        end_test("discard");

        // Fill the store queue with retired but unacked stores
        store_ack_en <= 1'b0;
        for (int i = 0; i < `LSQ_SQ_DEPTH; i++) begin
            offset = OFF_W'($random(seed));
            page = PAGE_W'($random(seed));
            data = $random(seed);
            store_exp.push_back({page, offset, data, 4'hf});
            issue_op(LS_STORE, offset, '0, data, 4'hf);
            send_addr(1'b0, page, 1'b0);
            check_value("full", full, i == `LSQ_SQ_DEPTH - 1);
            retire_store(1'b1);
        end
        ack_mark = store_ack_count;
        store_ack_en <= 1'b1;
        wait_until(W_STORE_ACKED, "first store ack", 1'b0);
        check_value("full", full, 1'b0);
        wait_until(W_STORES_DRAINED, "store queue to drain", 1'b0);
        wait_until(W_IDLE, "queue to go idle", 1'b0);
        end_test("full and drain");

        $display("%0d tests run, %0d errors", tests_done, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* src/load_store_queue.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module load_store_queue (
    input  wire logic clk,
    input  wire logic rst,
    // Issue side
    input  wire logic op_push,
    input  wire lsq_pkg::ls_op_t op_kind,
    input  wire logic [`LSQ_OFFSET_W-1:0] op_offset,
    input  wire logic [`LSQ_ID_W-1:0] op_id,
    input  wire logic [`LSQ_DATA_W-1:0] op_data,
    input  wire logic [`LSQ_BE_W-1:0] op_be,
    // Translation side
    input  wire logic addr_push,
    input  wire logic addr_rnw,
    input  wire logic [`LSQ_PAGE_W-1:0] addr_page,
    input  wire logic addr_discard,
    input  wire logic store_retire,
    // Memory side
    input  wire logic load_ack,
    input  wire logic store_ack,
    output logic load_valid,
    output logic [`LSQ_PAGE_W+`LSQ_OFFSET_W-1:0] load_addr,
    output logic [`LSQ_ID_W-1:0] load_id,
    output logic store_valid,
    output logic [`LSQ_PAGE_W+`LSQ_OFFSET_W-1:0] store_addr,
    output logic [`LSQ_DATA_W-1:0] store_data,
    output logic [`LSQ_BE_W-1:0] store_be,
    output logic full,
    output logic empty,
    output logic sq_empty
);

    import lsq_pkg::*;

    logic lq_push;
    logic sq_push;
    logic lq_addr_push;
    logic sq_addr_push;
    logic lq_pop;
    logic sq_pop;
    logic lq_addr_pop;
    logic sq_addr_pop;
    logic lq_valid;
    logic lq_addr_valid;
    logic sq_addr_valid;
    logic sq_head_valid;
    logic sq_full;
    logic potential_conflict;
    logic [`LSQ_HASH_W-1:0] load_hash;
    sq_ptr_t sq_windex;
    sq_ptr_t sq_rindex;
    lq_entry_t lq_entry;
    lq_entry_t lq_head;
    sq_entry_t sq_entry;
    sq_entry_t sq_head;
    addr_entry_t addr_entry;
    addr_entry_t lq_addr_head;
    addr_entry_t sq_addr_head;

    // Ops are refused whenever stores have nowhere to go
    assign full = sq_full;

    lsq_intake intake_i (
        .op_push(op_push),
        .addr_push(addr_push),
        .addr_rnw(addr_rnw),
        .addr_discard(addr_discard),
        .potential_conflict(potential_conflict),
        .sq_full(sq_full),
        .op_kind(op_kind),
        .op_offset(op_offset),
        .op_id(op_id),
        .op_data(op_data),
        .op_be(op_be),
        .addr_page(addr_page),
        .sq_windex(sq_windex),
        .lq_push(lq_push),
        .sq_push(sq_push),
        .lq_addr_push(lq_addr_push),
        .sq_addr_push(sq_addr_push),
        .load_hash(load_hash),
        .lq_entry(lq_entry),
        .sq_entry(sq_entry),
        .addr_entry(addr_entry)
    );

    //////////////////////////////
    // Load queue and its addresses
    //////////////////////////////
    lsq_fifo #(.WIDTH($bits(lq_entry_t)), .DEPTH(`LSQ_LQ_DEPTH)) lq_fifo_i (
        .clk(clk),
        .rst(rst),
        .push(lq_push),
        .pop(lq_pop),
        .data_in(lq_entry),
        .valid(lq_valid),
        .full(),
        .data_out(lq_head)
    );

    lsq_fifo #(.WIDTH($bits(addr_entry_t)), .DEPTH(`LSQ_LQ_DEPTH)) lq_addr_fifo_i (
        .clk(clk),
        .rst(rst),
        .push(lq_addr_push),
        .pop(lq_addr_pop),
        .data_in(addr_entry),
        .valid(lq_addr_valid),
        .full(),
        .data_out(lq_addr_head)
    );

    //////////////////////////////
    // Store queue and its addresses
    //////////////////////////////
    lsq_store_queue sq_i (
        .clk(clk),
        .rst(rst),
        .push(sq_push),
        .retire(store_retire),
        .pop(sq_pop),
        .entry_in(sq_entry),
        .load_hash(load_hash),
        .full(sq_full),
        .potential_conflict(potential_conflict),
        .head_valid(sq_head_valid),
        .empty(sq_empty),
        .windex(sq_windex),
        .rindex(sq_rindex),
        .head(sq_head)
    );

    lsq_fifo #(.WIDTH($bits(addr_entry_t)), .DEPTH(`LSQ_SQ_DEPTH)) sq_addr_fifo_i (
        .clk(clk),
        .rst(rst),
        .push(sq_addr_push),
        .pop(sq_addr_pop),
        .data_in(addr_entry),
        .valid(sq_addr_valid),
        .full(),
        .data_out(sq_addr_head)
    );

    lsq_issue issue_i (
        .lq_valid(lq_valid),
        .lq_addr_valid(lq_addr_valid),
        .sq_head_valid(sq_head_valid),
        .sq_addr_valid(sq_addr_valid),
        .addr_push(addr_push),
        .addr_rnw(addr_rnw),
        .addr_discard(addr_discard),
        .load_ack(load_ack),
        .store_ack(store_ack),
        .sq_empty(sq_empty),
        .lq_head(lq_head),
        .sq_head(sq_head),
        .lq_addr_head(lq_addr_head),
        .sq_addr_head(sq_addr_head),
        .addr_page(addr_page),
        .sq_rindex(sq_rindex),
        .lq_pop(lq_pop),
        .lq_addr_pop(lq_addr_pop),
        .sq_pop(sq_pop),
        .sq_addr_pop(sq_addr_pop),
        .load_valid(load_valid),
        .store_valid(store_valid),
        .load_addr(load_addr),
        .load_id(load_id),
        .store_addr(store_addr),
        .store_data(store_data),
        .store_be(store_be),
        .empty(empty)
    );

endmodule

`default_nettype wire

/* src/lsq_issue.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module lsq_issue (
    input  wire logic lq_valid,
    input  wire logic lq_addr_valid,
    input  wire logic sq_head_valid,
    input  wire logic sq_addr_valid,
    input  wire logic addr_push,
    input  wire logic addr_rnw,
    input  wire logic addr_discard,
    input  wire logic load_ack,
    input  wire logic store_ack,
    input  wire logic sq_empty,
    input  wire lsq_pkg::lq_entry_t lq_head,
    input  wire lsq_pkg::sq_entry_t sq_head,
    input  wire lsq_pkg::addr_entry_t lq_addr_head,
    input  wire lsq_pkg::addr_entry_t sq_addr_head,
    input  wire logic [`LSQ_PAGE_W-1:0] addr_page,
    input  wire lsq_pkg::sq_ptr_t sq_rindex,
    output logic lq_pop,
    output logic lq_addr_pop,
    output logic sq_pop,
    output logic sq_addr_pop,
    output logic load_valid,
    output logic store_valid,
    output logic [`LSQ_PAGE_W+`LSQ_OFFSET_W-1:0] load_addr,
    output logic [`LSQ_ID_W-1:0] load_id,
    output logic [`LSQ_PAGE_W+`LSQ_OFFSET_W-1:0] store_addr,
    output logic [`LSQ_DATA_W-1:0] store_data,
    output logic [`LSQ_BE_W-1:0] store_be,
    output logic empty
);

    import lsq_pkg::*;

    addr_entry_t bypass_addr;
    addr_entry_t lq_addr;
    addr_entry_t sq_addr;
    logic lq_addr_ready;
    logic sq_addr_ready;
    logic load_blocked;
    logic lq_discard;
    logic sq_discard;

    //////////////////////////////
    // Address pairing
    //////////////////////////////

    // Same-cycle address push stands in for an empty address FIFO
    assign bypass_addr.page = addr_page;
    assign bypass_addr.discard = addr_discard;

    assign lq_addr = lq_addr_valid ? lq_addr_head : bypass_addr;
    assign sq_addr = sq_addr_valid ? sq_addr_head : bypass_addr;

    assign lq_addr_ready = lq_addr_valid | (addr_push & addr_rnw);
    assign sq_addr_ready = sq_addr_valid | (addr_push & ~addr_rnw);

    // Older colliding stores still in the queue
    assign load_blocked = lq_head.store_collision & (lq_head.sq_index != sq_rindex);

    //////////////////////////////
    // Discard
    //////////////////////////////

    // Faulted load leaves at once
    assign lq_discard = lq_valid & lq_addr_ready & lq_addr.discard;
    // Faulted store waits for a cycle with no load to send
    assign sq_discard = sq_head_valid & sq_addr_ready & sq_addr.discard
        & (~lq_valid | load_blocked);

    //////////////////////////////
    // Requests
    //////////////////////////////
    assign load_valid = lq_valid & lq_addr_ready & ~lq_addr.discard & ~load_blocked;
    assign store_valid = sq_head_valid & sq_addr_ready & ~sq_addr.discard;

    assign lq_pop = (load_valid & load_ack) | lq_discard;
    assign lq_addr_pop = lq_pop;
    assign sq_pop = (store_valid & store_ack) | sq_discard;
    assign sq_addr_pop = sq_pop;

    assign load_addr = {lq_addr.page, lq_head.offset};
    assign load_id = lq_head.id;

    assign store_addr = {sq_addr.page, sq_head.offset};
    assign store_data = sq_head.data;
    assign store_be = sq_head.be;

    assign empty = ~lq_valid & sq_empty;

endmodule

`default_nettype wire

/* src/lsq_intake.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module lsq_intake (
    input  wire logic op_push,
    input  wire logic addr_push,
    input  wire logic addr_rnw,
    input  wire logic addr_discard,
    input  wire logic potential_conflict,
    input  wire logic sq_full,
    input  wire lsq_pkg::ls_op_t op_kind,
    input  wire logic [`LSQ_OFFSET_W-1:0] op_offset,
    input  wire logic [`LSQ_ID_W-1:0] op_id,
    input  wire logic [`LSQ_DATA_W-1:0] op_data,
    input  wire logic [`LSQ_BE_W-1:0] op_be,
    input  wire logic [`LSQ_PAGE_W-1:0] addr_page,
    input  wire lsq_pkg::sq_ptr_t sq_windex,
    output logic lq_push,
    output logic sq_push,
    output logic lq_addr_push,
    output logic sq_addr_push,
    output logic [`LSQ_HASH_W-1:0] load_hash,
    output lsq_pkg::lq_entry_t lq_entry,
    output lsq_pkg::sq_entry_t sq_entry,
    output lsq_pkg::addr_entry_t addr_entry
);

    import lsq_pkg::*;

    //////////////////////////////
    // Offset hash
    //////////////////////////////

    // XOR fold of the word offset, byte bits left out
    always_comb begin
        load_hash = '0;
        for (int i = 2; i < `LSQ_OFFSET_W; i++) begin
            load_hash[(i - 2) % `LSQ_HASH_W] = load_hash[(i - 2) % `LSQ_HASH_W] ^ op_offset[i];
        end
    end

    //////////////////////////////
    // Push routing
    //////////////////////////////

    // Nothing is accepted while the store queue is full
    assign lq_push = op_push & ~sq_full & (op_kind == LS_LOAD);
    assign sq_push = op_push & ~sq_full & (op_kind == LS_STORE);

    assign lq_addr_push = addr_push & addr_rnw;
    assign sq_addr_push = addr_push & ~addr_rnw;

    // Load entry remembers where the store queue stood
    assign lq_entry.offset = op_offset;
    assign lq_entry.id = op_id;
    assign lq_entry.store_collision = potential_conflict;
    assign lq_entry.sq_index = sq_windex;

    // Store entry carries its own hash for later loads
    assign sq_entry.offset = op_offset;
    assign sq_entry.data = op_data;
    assign sq_entry.be = op_be;
    assign sq_entry.hash = load_hash;

    assign addr_entry.page = addr_page;
    assign addr_entry.discard = addr_discard;

endmodule

`default_nettype wire

/* src/lsq_store_queue.sv */
`default_nettype none
`timescale 1ns/1ns

`include "lsq_cfg.svh"

module lsq_store_queue (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic push,
    input  wire logic retire,
    input  wire logic pop,
    input  wire lsq_pkg::sq_entry_t entry_in,
    input  wire logic [`LSQ_HASH_W-1:0] load_hash,
    output logic full,
    output logic potential_conflict,
    output logic head_valid,
    output logic empty,
    output lsq_pkg::sq_ptr_t windex,
    output lsq_pkg::sq_ptr_t rindex,
    output lsq_pkg::sq_entry_t head
);

    import lsq_pkg::*;

    localparam int IDX_W = $clog2(`LSQ_SQ_DEPTH);

    sq_entry_t mem [`LSQ_SQ_DEPTH];
    logic [`LSQ_SQ_DEPTH-1:0] entry_valid;
    logic [`LSQ_SQ_DEPTH-1:0] entry_retired;
    logic [`LSQ_SQ_DEPTH-1:0] hash_hit;

    // Wide pointers with a wrap bit to tell full from empty
    sq_ptr_t wptr;
    sq_ptr_t rptr;
    // Oldest store still waiting on retire
    logic [IDX_W-1:0] retire_idx;

    logic [IDX_W-1:0] widx;
    logic [IDX_W-1:0] ridx;
    logic wr_en;
    logic rd_en;

    assign widx = wptr[IDX_W-1:0];
    assign ridx = rptr[IDX_W-1:0];

    assign empty = (wptr == rptr);
    assign full = (wptr[IDX_W] != rptr[IDX_W]) && (widx == ridx);

    assign windex = wptr;
    assign rindex = rptr;

    // Head is only offered once retired
    assign head = mem[ridx];
    assign head_valid = entry_valid[ridx] & entry_retired[ridx];

    assign wr_en = push & ~full;
    assign rd_en = pop & head_valid;

    //////////////////////////////
    // Collision check
    //////////////////////////////

    // Match incoming load hash against every live store
    always_comb begin
        for (int i = 0; i < `LSQ_SQ_DEPTH; i++) begin
            hash_hit[i] = entry_valid[i] & (mem[i].hash == load_hash);
        end
    end

    assign potential_conflict = |hash_hit;

    //////////////////////////////
    // Control state
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
            retire_idx <= '0;
            entry_valid <= '0;
            entry_retired <= '0;
        end else begin
            if (rd_en) begin
                entry_valid[ridx] <= 1'b0;
                entry_retired[ridx] <= 1'b0;
                rptr <= rptr + 1'b1;
            end
            if (wr_en) begin
                entry_valid[widx] <= 1'b1;
                entry_retired[widx] <= 1'b0;
                wptr <= wptr + 1'b1;
            end
            // Retire after push so a store retired as it enters is kept retired
            if (retire) begin
                entry_retired[retire_idx] <= 1'b1;
                retire_idx <= retire_idx + 1'b1;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[widx] <= entry_in;
    end

endmodule

`default_nettype wire

/* src/lsq_fifo.sv */
`default_nettype none
`timescale 1ns/1ns

module lsq_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic push,
    input  wire logic pop,
    input  wire logic [WIDTH-1:0] data_in,
    output logic valid,
    output logic full,
    output logic [WIDTH-1:0] data_out
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] count;
    logic wr_en;
    logic rd_en;

    assign valid = (count != '0);
    assign full = (count == CNT_W'(DEPTH));

    // Pop on an empty FIFO still counts when a push lands the same cycle
    // The entry then passes straight through without being kept
    assign wr_en = push & ~full;
    assign rd_en = pop & (valid | wr_en);

    // Head comes straight from storage
    assign data_out = mem[rptr];

    //////////////////////////////
    // Pointers and count
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
        end else begin
            if (wr_en)
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            if (rd_en)
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            // Count only moves on one-sided traffic
            if (wr_en & ~rd_en)
                count <= count + 1'b1;
            else if (rd_en & ~wr_en)
                count <= count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wptr] <= data_in;
    end

endmodule

`default_nettype wire

/* src/lsq_pkg.sv */
`default_nettype none

`include "lsq_cfg.svh"

package lsq_pkg;

    // Kind of an issue push
    typedef enum logic {
        LS_LOAD  = 1'b0,
        LS_STORE = 1'b1
    } ls_op_t;

    // Store queue pointer, one extra bit for wrap
    typedef logic [$clog2(`LSQ_SQ_DEPTH):0] sq_ptr_t;

    // Load queue entry
    typedef struct packed {
        logic [`LSQ_OFFSET_W-1:0] offset;
        logic [`LSQ_ID_W-1:0] id;
        // Hash hit against some pending store at push time
        logic store_collision;
        // Store queue write pointer when the load was pushed
        sq_ptr_t sq_index;
    } lq_entry_t;

    // Store queue entry
    typedef struct packed {
        logic [`LSQ_OFFSET_W-1:0] offset;
        logic [`LSQ_DATA_W-1:0] data;
        logic [`LSQ_BE_W-1:0] be;
        logic [`LSQ_HASH_W-1:0] hash;
    } sq_entry_t;

    // Translated address, shared by both address FIFOs
    typedef struct packed {
        logic [`LSQ_PAGE_W-1:0] page;
        logic discard;
    } addr_entry_t;

endpackage

`default_nettype wire

/* src/lsq_cfg.svh */
`ifndef LSQ_CFG_SVH
`define LSQ_CFG_SVH

//////////////////////////////
// Address split
//////////////////////////////

// Offset within the page, untranslated
`define LSQ_OFFSET_W 12
// Translated page number
`define LSQ_PAGE_W 20

//////////////////////////////
// Payload
//////////////////////////////

`define LSQ_DATA_W 32
`define LSQ_BE_W 4
// Operation ID, also bounds the number of loads in flight
`define LSQ_ID_W 3
// Folded offset hash for store collision checks
`define LSQ_HASH_W 4

//////////////////////////////
// Queue depths
//////////////////////////////

// One slot per ID
`define LSQ_LQ_DEPTH 8
`define LSQ_SQ_DEPTH 4

`endif
